// File: project.f
muldiv_cfg_pkg.sv
muldiv_msg_pkg.sv
muldiv_req_queue.sv
int_div_iterative.sv
int_mul_iterative.sv
muldiv_resp_seq.sv
muldiv_unit.sv
muldiv_props.sv
muldiv_tb.sv

// File: Makefile
# Verilator build and run of the multiply/divide unit testbench

obj_dir/Vmuldiv_tb: project.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module muldiv_tb -f project.f

run: obj_dir/Vmuldiv_tb
	obj_dir/Vmuldiv_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -qF '*** FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: muldiv_tb.sv
/*
 * testbench for the multiply/divide unit
 * clock, stimulus, reference model, response checker and summary
 */
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;

  // wait limit in cycles for every handshake loop
  localparam int TIMEOUT  = 2000;
  localparam int N_RANDOM = 300;

  logic                                clk;
  logic                                reset;
  logic                                req_val;
  logic                                req_rdy;
  logic [muldiv_msg_pkg::FN_W-1:0]     req_fn;
  logic [muldiv_cfg_pkg::DATA_W-1:0]   req_a;
  logic [muldiv_cfg_pkg::DATA_W-1:0]   req_b;
  logic                                resp_val;
  logic                                resp_rdy;
  logic [muldiv_cfg_pkg::RESULT_W-1:0] resp_result;

  // expected results in request order
  logic [muldiv_cfg_pkg::RESULT_W-1:0] exp_q [$];

  int   errors;
  int   n_resp;
  int   seed;
  int   bp_seed;
  logic bp_en;
  logic both_busy;

  muldiv_unit i_dut (
    .clk, .reset, .req_val, .req_rdy, .req_fn, .req_a, .req_b,
    .resp_val, .resp_rdy, .resp_result
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  // product, or {remainder, quotient} with truncating division
  function automatic logic [63:0] muldiv_model(input logic [1:0] fn,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [31:0] q;
    logic [31:0] r;
    int          sa;
    int          sb;
    sa = a;
    sb = b;
    q  = '0;
    r  = '0;
    case (fn)
      muldiv_msg_pkg::FN_MULU: begin
        return {32'd0, a} * {32'd0, b};
      end
      muldiv_msg_pkg::FN_DIVU: begin
        // divide by zero gives all ones and the dividend back
        if (b == 32'd0) begin
          q = '1;
          r = a;
        end else begin
          q = a / b;
          r = a % b;
        end
      end
      default: begin
        // the one signed overflow case
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          q = a;
          r = '0;
        end else if (b != 32'd0) begin
          q = sa / sb;
          r = sa % sb;
        end
      end
    endcase
    return {r, q};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d  responses checked: %0d  outstanding: %0d",
             errors, n_resp, exp_q.size());
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    $display("timeout at %0t: %s", $time, what);
    errors++;
    finish_run();
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  // called just after a rising edge, returns just after the transfer edge
  task automatic send_req(input logic [1:0] fn, input logic [31:0] a, input logic [31:0] b);
    int waited;
    waited = 0;
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(negedge clk);
    while (!req_rdy && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      abort_run("request was not accepted");
    end else begin
      exp_q.push_back(muldiv_model(fn, a, b));
      @(posedge clk);
    end
  endtask

  task automatic idle_cycle();
    req_val <= 1'b0;
    @(posedge clk);
  endtask

  task automatic send_random();
    int          pick;
    logic [1:0]  fn;
    logic [31:0] a;
    logic [31:0] b;
    pick = $unsigned($random(seed)) % 3;
    a    = $random(seed);
    b    = $random(seed);
    // spread divisor sizes so quotients vary
    b    = b >> ($unsigned($random(seed)) % 32);
    case (pick)
      0:       fn = muldiv_msg_pkg::FN_MULU;
      1:       fn = muldiv_msg_pkg::FN_DIV;
      default: fn = muldiv_msg_pkg::FN_DIVU;
    endcase
    if (fn == muldiv_msg_pkg::FN_DIV && ($random(seed) & 1)) b = -b;
    // signed divide by zero has no defined result
    if (fn == muldiv_msg_pkg::FN_DIV && b == 32'd0) b = 32'd1;
    send_req(fn, a, b);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    // stop offering the last request
    req_val <= 1'b0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      abort_run("responses still missing after the last request");
    end else begin
      idle_cycle();
    end
  endtask

  // output back-pressure, ready about three cycles in four
  always @(posedge clk) begin
    resp_rdy <= !bp_en || (($random(bp_seed) & 3) != 0);
  end

  // --------------------------------------------------
  // response compare, sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t with no request outstanding", $time);
        errors++;
      end else begin
        check_value("resp_result", resp_result, exp_q.pop_front());
        n_resp++;
      end
    end
    // both units busy at once
    if (!reset && !i_dut.div_req_rdy && !i_dut.mul_req_rdy) both_busy = 1'b1;
  end

  initial begin
    reset     = 1'b1;
    req_val   = 1'b0;
    req_fn    = '0;
    req_a     = '0;
    req_b     = '0;
    resp_rdy  = 1'b0;
    errors    = 0;
    n_resp    = 0;
    seed      = 32'hab20;
    // separate stream for back-pressure
    bp_seed   = seed + 1;
    bp_en     = 1'b0;
    both_busy = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // directed multiply
    send_req(muldiv_msg_pkg::FN_MULU, 32'd0, 32'd0);
    send_req(muldiv_msg_pkg::FN_MULU, 32'd0, 32'hffff_ffff);
    send_req(muldiv_msg_pkg::FN_MULU, 32'd1, 32'h1234_5678);
    send_req(muldiv_msg_pkg::FN_MULU, 32'hffff_ffff, 32'hffff_ffff);
    for (int i = 0; i < 32; i += 3) begin
      send_req(muldiv_msg_pkg::FN_MULU, 32'd1 << i, 32'd1 << ((i * 7) % 32));
    end
    send_req(muldiv_msg_pkg::FN_MULU, 32'h8000_0000, 32'h8000_0000);
    wait_drain();

    // signed divide, all sign pairs and the overflow case
    send_req(muldiv_msg_pkg::FN_DIV, 32'd7, 32'd2);
    send_req(muldiv_msg_pkg::FN_DIV, -32'd7, 32'd2);
    send_req(muldiv_msg_pkg::FN_DIV, 32'd7, -32'd2);
    send_req(muldiv_msg_pkg::FN_DIV, -32'd7, -32'd2);
    send_req(muldiv_msg_pkg::FN_DIV, -32'd5, 32'd7);
    send_req(muldiv_msg_pkg::FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_req(muldiv_msg_pkg::FN_DIV, 32'h8000_0000, 32'd1);
    wait_drain();

    // unsigned divide including divide by zero
    send_req(muldiv_msg_pkg::FN_DIVU, 32'd1234, 32'd0);
    send_req(muldiv_msg_pkg::FN_DIVU, 32'hffff_ffff, 32'd0);
    send_req(muldiv_msg_pkg::FN_DIVU, 32'hffff_ffff, 32'd1);
    send_req(muldiv_msg_pkg::FN_DIVU, 32'd100, 32'd7);
    wait_drain();

    // random mix under back-pressure
    bp_en = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      if (($random(seed) & 7) == 0) idle_cycle();
      send_random();
    end
    wait_drain();
    bp_en = 1'b0;

    // alternating back-to-back multiply and divide
    both_busy = 1'b0;
    for (int n = 0; n < 20; n++) begin
      send_req(muldiv_msg_pkg::FN_MULU, 32'd1000 + n, 32'd3 * n + 1);
      send_req(muldiv_msg_pkg::FN_DIVU, 32'hdead_0000 + n, 32'd17 + n);
    end
    wait_drain();
    if (!both_busy) begin
      $display("multiply and divide were never in flight together");
      errors++;
    end

    finish_run();
  end

endmodule

`default_nettype wire

// File: muldiv_props.sv
/*
 * handshake and latency assertions, bound to the unit top level
 */
`timescale 1ns/100ps
`default_nettype none

module muldiv_props (
  input logic                                clk,
  input logic                                reset,
  input logic                                req_val,
  input logic                                req_rdy,
  input logic [muldiv_msg_pkg::FN_W-1:0]     req_fn,
  input logic [muldiv_cfg_pkg::DATA_W-1:0]   req_a,
  input logic [muldiv_cfg_pkg::DATA_W-1:0]   req_b,
  input logic                                resp_val,
  input logic                                resp_rdy,
  input logic [muldiv_cfg_pkg::RESULT_W-1:0] resp_result
);

  // cycle stamp of each accepted request, read back in order
  int unsigned cyc;
  int unsigned req_time [8];
  logic [2:0]  wr_ptr;
  logic [2:0]  rd_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      cyc    <= 0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      cyc <= cyc + 1;
      if (req_val && req_rdy) begin
        req_time[wr_ptr] <= cyc;
        wr_ptr           <= wr_ptr + 1'b1;
      end
      if (resp_val && resp_rdy) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> (req_val && $stable(req_fn) && $stable(req_a) && $stable(req_b)))
    else $error("request dropped or changed before transfer");

  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else $error("response dropped or changed while stalled");

  assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high right after reset");

  // minimum latency is 34 cycles
  assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (cyc - req_time[rd_ptr] >= 34))
    else $error("response earlier than 34 cycles after its request");

endmodule

bind muldiv_unit muldiv_props i_props (
  .clk(clk), .reset(reset), .req_val(req_val), .req_rdy(req_rdy), .req_fn(req_fn),
  .req_a(req_a), .req_b(req_b), .resp_val(resp_val), .resp_rdy(resp_rdy),
  .resp_result(resp_result)
);

`default_nettype wire

// File: muldiv_unit.sv
/*
 * multiply/divide unit top, request queue, both units and sequencer
 */
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  logic [muldiv_msg_pkg::FN_W-1:0]     req_fn,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0]   req_a,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0]   req_b,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output logic [muldiv_cfg_pkg::RESULT_W-1:0] resp_result
);

  // dispatch side
  logic                              div_req_val;
  logic                              div_req_rdy;
  logic                              div_req_signed;
  logic                              mul_req_val;
  logic                              mul_req_rdy;
  logic [muldiv_cfg_pkg::DATA_W-1:0] op_a;
  logic [muldiv_cfg_pkg::DATA_W-1:0] op_b;

  // order tags
  logic ord_push;
  logic ord_tag;
  logic ord_rdy;

  // unit responses
  logic                           div_resp_val;
  logic                           div_resp_rdy;
  muldiv_msg_pkg::muldiv_result_u div_resp_result;
  logic                           mul_resp_val;
  logic                           mul_resp_rdy;
  muldiv_msg_pkg::muldiv_result_u mul_resp_result;

  muldiv_req_queue i_req_queue (
    .clk, .reset, .req_val, .req_rdy, .req_fn, .req_a, .req_b,
    .div_req_val, .div_req_signed, .div_req_rdy, .mul_req_val, .mul_req_rdy,
    .op_a, .op_b, .ord_push, .ord_tag, .ord_rdy
  );

  int_div_iterative i_div (
    .clk, .reset, .div_req_val, .div_req_rdy, .div_req_signed, .op_a, .op_b,
    .div_resp_val, .div_resp_rdy, .div_resp_result
  );

  int_mul_iterative i_mul (
    .clk, .reset, .mul_req_val, .mul_req_rdy, .op_a, .op_b,
    .mul_resp_val, .mul_resp_rdy, .mul_resp_result
  );

  muldiv_resp_seq i_resp_seq (
    .clk, .reset, .ord_push, .ord_tag, .ord_rdy,
    .div_resp_val, .div_resp_rdy, .div_resp_result,
    .mul_resp_val, .mul_resp_rdy, .mul_resp_result,
    .resp_val, .resp_rdy, .resp_result
  );

endmodule

`default_nettype wire

// File: muldiv_resp_seq.sv
/*
 * response sequencer, order FIFO of unit tags and in-order merge
 */
`timescale 1ns/100ps
`default_nettype none

module muldiv_resp_seq (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                ord_push,
  input  logic                                ord_tag,
  output logic                                ord_rdy,
  input  logic                                div_resp_val,
  output logic                                div_resp_rdy,
  input  muldiv_msg_pkg::muldiv_result_u      div_resp_result,
  input  logic                                mul_resp_val,
  output logic                                mul_resp_rdy,
  input  muldiv_msg_pkg::muldiv_result_u      mul_resp_result,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output logic [muldiv_cfg_pkg::RESULT_W-1:0] resp_result
);

  // tag storage
  logic tag_mem [muldiv_cfg_pkg::ORDER_DEPTH];

  logic [$clog2(muldiv_cfg_pkg::ORDER_DEPTH)-1:0]   head_ptr;
  logic [$clog2(muldiv_cfg_pkg::ORDER_DEPTH)-1:0]   tail_ptr;
  logic [$clog2(muldiv_cfg_pkg::ORDER_DEPTH+1)-1:0] count;

  logic head_val;
  logic head_is_div;
  logic pop;

  // --------------------------------------------------
  // head selects which unit drives the output
  // --------------------------------------------------
  assign ord_rdy     = (count != muldiv_cfg_pkg::ORDER_DEPTH);
  assign head_val    = (count != 0);
  assign head_is_div = (tag_mem[head_ptr] == muldiv_msg_pkg::TAG_DIV);

  // a finished unit not at the head sees rdy low and waits
  assign resp_val     = head_val && (head_is_div ? div_resp_val : mul_resp_val);
  assign div_resp_rdy = head_val && head_is_div && resp_rdy;
  assign mul_resp_rdy = head_val && !head_is_div && resp_rdy;
  assign resp_result  = head_is_div ? div_resp_result : mul_resp_result;

  assign pop = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (ord_push) begin
      tag_mem[tail_ptr] <= ord_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (ord_push) begin
        tail_ptr <= (tail_ptr == muldiv_cfg_pkg::ORDER_DEPTH - 1) ? '0 : tail_ptr + 1'b1;
      end
      if (pop) begin
        head_ptr <= (head_ptr == muldiv_cfg_pkg::ORDER_DEPTH - 1) ? '0 : head_ptr + 1'b1;
      end
      if (ord_push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !ord_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: int_mul_iterative.sv
/*
 * iterative shift-add multiplier, unsigned 32x32 to 64
 */
`timescale 1ns/100ps
`default_nettype none

module int_mul_iterative (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              mul_req_val,
  output logic                              mul_req_rdy,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0] op_a,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0] op_b,
  output logic                              mul_resp_val,
  input  logic                              mul_resp_rdy,
  output muldiv_msg_pkg::muldiv_result_u    mul_resp_result
);

  logic [1:0]                          state;
  logic [muldiv_cfg_pkg::CNT_W-1:0]    cnt;

  // multiplicand shifts left, multiplier shifts right
  logic [muldiv_cfg_pkg::RESULT_W-1:0] mcand_reg;
  logic [muldiv_cfg_pkg::DATA_W-1:0]   mplier_reg;
  logic [muldiv_cfg_pkg::RESULT_W-1:0] prod_reg;

  logic accept;
  logic respond;

  // --------------------------------------------------
  // handshake and controller
  // --------------------------------------------------
  assign mul_req_rdy  = (state == muldiv_cfg_pkg::ST_IDLE);
  assign mul_resp_val = (state == muldiv_cfg_pkg::ST_DONE);
  assign accept       = mul_req_val && mul_req_rdy;
  assign respond      = mul_resp_val && mul_resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_cfg_pkg::ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        muldiv_cfg_pkg::ST_IDLE: begin
          if (accept) begin
            state <= muldiv_cfg_pkg::ST_CALC;
            cnt   <= '1;
          end
        end
        muldiv_cfg_pkg::ST_CALC: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= muldiv_cfg_pkg::ST_DONE;
          end
        end
        muldiv_cfg_pkg::ST_DONE: begin
          if (respond) begin
            state <= muldiv_cfg_pkg::ST_IDLE;
          end
        end
        default: state <= muldiv_cfg_pkg::ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      mcand_reg  <= {{muldiv_cfg_pkg::DATA_W{1'b0}}, op_a};
      mplier_reg <= op_b;
      prod_reg   <= '0;
    end else if (state == muldiv_cfg_pkg::ST_CALC) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_reg[0]) begin
        prod_reg <= prod_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  always_comb begin
    mul_resp_result.product = prod_reg;
  end

endmodule

`default_nettype wire

// File: int_div_iterative.sv
/*
 * iterative restoring divider, 32 shift-subtract steps
 * IDLE/CALC/DONE controller, count-down counter and sign fixup
 */
`timescale 1ns/100ps
`default_nettype none

module int_div_iterative (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              div_req_val,
  output logic                              div_req_rdy,
  input  logic                              div_req_signed,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0] op_a,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0] op_b,
  output logic                              div_resp_val,
  input  logic                              div_resp_rdy,
  output muldiv_msg_pkg::muldiv_result_u    div_resp_result
);

  logic [1:0]                        state;
  logic [muldiv_cfg_pkg::CNT_W-1:0]  cnt;

  // 65-bit shift register, remainder in [63:32], quotient in [31:0]
  logic [muldiv_cfg_pkg::RESULT_W:0] a_reg;
  // divisor aligned to the upper half
  logic [muldiv_cfg_pkg::RESULT_W:0] b_reg;

  // sign fixup flags captured at accept
  logic quot_neg;
  logic rem_neg;

  logic                              accept;
  logic                              respond;
  logic [muldiv_cfg_pkg::DATA_W-1:0] mag_a;
  logic [muldiv_cfg_pkg::DATA_W-1:0] mag_b;
  logic [muldiv_cfg_pkg::RESULT_W:0] a_shift;
  logic [muldiv_cfg_pkg::RESULT_W:0] diff;
  logic [muldiv_cfg_pkg::DATA_W-1:0] quot;
  logic [muldiv_cfg_pkg::DATA_W-1:0] rem;

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  assign div_req_rdy  = (state == muldiv_cfg_pkg::ST_IDLE);
  assign div_resp_val = (state == muldiv_cfg_pkg::ST_DONE);
  assign accept       = div_req_val && div_req_rdy;
  assign respond      = div_resp_val && div_resp_rdy;

  // controller
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_cfg_pkg::ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        muldiv_cfg_pkg::ST_IDLE: begin
          if (accept) begin
            state <= muldiv_cfg_pkg::ST_CALC;
            cnt   <= '1;
          end
        end
        muldiv_cfg_pkg::ST_CALC: begin
          // last step runs with cnt at zero
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= muldiv_cfg_pkg::ST_DONE;
          end
        end
        muldiv_cfg_pkg::ST_DONE: begin
          if (respond) begin
            state <= muldiv_cfg_pkg::ST_IDLE;
          end
        end
        default: state <= muldiv_cfg_pkg::ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  // magnitudes for signed requests, raw operands otherwise
  assign mag_a = (div_req_signed && op_a[muldiv_cfg_pkg::DATA_W-1]) ? -op_a : op_a;
  assign mag_b = (div_req_signed && op_b[muldiv_cfg_pkg::DATA_W-1]) ? -op_b : op_b;

  // one shift-subtract step
  assign a_shift = a_reg << 1;
  assign diff    = a_shift - b_reg;

  always_ff @(posedge clk) begin
    if (accept) begin
      a_reg    <= {{(muldiv_cfg_pkg::DATA_W+1){1'b0}}, mag_a};
      b_reg    <= {1'b0, mag_b, {muldiv_cfg_pkg::DATA_W{1'b0}}};
      quot_neg <= div_req_signed && (op_a[muldiv_cfg_pkg::DATA_W-1] ^
                                     op_b[muldiv_cfg_pkg::DATA_W-1]);
      rem_neg  <= div_req_signed && op_a[muldiv_cfg_pkg::DATA_W-1];
    end else if (state == muldiv_cfg_pkg::ST_CALC) begin
      // negative difference means restore and shift in a zero
      if (diff[muldiv_cfg_pkg::RESULT_W]) begin
        a_reg <= {a_shift[muldiv_cfg_pkg::RESULT_W:1], 1'b0};
      end else begin
        a_reg <= {diff[muldiv_cfg_pkg::RESULT_W:1], 1'b1};
      end
    end
  end

  // sign fixup on the way out
  assign quot = a_reg[muldiv_cfg_pkg::DATA_W-1:0];
  assign rem  = a_reg[muldiv_cfg_pkg::RESULT_W-1:muldiv_cfg_pkg::DATA_W];

  always_comb begin
    div_resp_result.divres.quot = quot_neg ? -quot : quot;
    div_resp_result.divres.rem  = rem_neg ? -rem : rem;
  end

endmodule

`default_nettype wire

// File: muldiv_req_queue.sv
/*
 * input request queue with function decode and dispatch to mul or div
 */
`timescale 1ns/100ps
`default_nettype none

module muldiv_req_queue (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  logic [muldiv_msg_pkg::FN_W-1:0]     req_fn,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0]   req_a,
  input  logic [muldiv_cfg_pkg::DATA_W-1:0]   req_b,
  output logic                                div_req_val,
  output logic                                div_req_signed,
  input  logic                                div_req_rdy,
  output logic                                mul_req_val,
  input  logic                                mul_req_rdy,
  output logic [muldiv_cfg_pkg::DATA_W-1:0]   op_a,
  output logic [muldiv_cfg_pkg::DATA_W-1:0]   op_b,
  output logic                                ord_push,
  output logic                                ord_tag,
  input  logic                                ord_rdy
);

  // circular buffer storage, payload only
  logic [muldiv_msg_pkg::FN_W-1:0]   fn_mem [muldiv_cfg_pkg::REQ_DEPTH];
  logic [muldiv_cfg_pkg::DATA_W-1:0] a_mem  [muldiv_cfg_pkg::REQ_DEPTH];
  logic [muldiv_cfg_pkg::DATA_W-1:0] b_mem  [muldiv_cfg_pkg::REQ_DEPTH];

  logic [$clog2(muldiv_cfg_pkg::REQ_DEPTH)-1:0]   head_ptr;
  logic [$clog2(muldiv_cfg_pkg::REQ_DEPTH)-1:0]   tail_ptr;
  logic [$clog2(muldiv_cfg_pkg::REQ_DEPTH+1)-1:0] count;

  logic                            push;
  logic                            pop;
  logic                            head_val;
  logic                            head_is_div;
  logic [muldiv_msg_pkg::FN_W-1:0] head_fn;

  // --------------------------------------------------
  // head decode
  // --------------------------------------------------
  assign head_val    = (count != 0);
  assign head_fn     = fn_mem[head_ptr];
  // anything that is not MULU goes to the divider
  assign head_is_div = (head_fn != muldiv_msg_pkg::FN_MULU);

  assign op_a           = a_mem[head_ptr];
  assign op_b           = b_mem[head_ptr];
  assign div_req_signed = (head_fn == muldiv_msg_pkg::FN_DIV);

  // offer the head only while the order FIFO has room
  // ord_rdy can only fall by our own push, so valid holds until transfer
  assign div_req_val = head_val && head_is_div && ord_rdy;
  assign mul_req_val = head_val && !head_is_div && ord_rdy;

  assign pop      = (div_req_val && div_req_rdy) || (mul_req_val && mul_req_rdy);
  assign ord_push = pop;
  assign ord_tag  = head_is_div ? muldiv_msg_pkg::TAG_DIV : muldiv_msg_pkg::TAG_MUL;

  // --------------------------------------------------
  // enqueue side
  // --------------------------------------------------
  assign req_rdy = (count != muldiv_cfg_pkg::REQ_DEPTH);
  assign push    = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      fn_mem[tail_ptr] <= req_fn;
      a_mem[tail_ptr]  <= req_a;
      b_mem[tail_ptr]  <= req_b;
    end
  end

  // pointers wrap at depth, count tracks occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        tail_ptr <= (tail_ptr == muldiv_cfg_pkg::REQ_DEPTH - 1) ? '0 : tail_ptr + 1'b1;
      end
      if (pop) begin
        head_ptr <= (head_ptr == muldiv_cfg_pkg::REQ_DEPTH - 1) ? '0 : head_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: muldiv_msg_pkg.sv
/*
 * function codes, unit tags and the result union
 */
`default_nettype none

package muldiv_msg_pkg;

  // function codes on req_fn
  localparam int         FN_W    = 2;
  localparam logic [1:0] FN_MULU = 2'd0;
  localparam logic [1:0] FN_DIV  = 2'd1;
  localparam logic [1:0] FN_DIVU = 2'd2;

  // unit tags carried through the order FIFO
  localparam logic TAG_MUL = 1'b0;
  localparam logic TAG_DIV = 1'b1;

  // divider view of the result word
  // remainder sits in the upper half, quotient in the lower
  typedef struct packed {
    logic [muldiv_cfg_pkg::DATA_W-1:0] rem;
    logic [muldiv_cfg_pkg::DATA_W-1:0] quot;
  } div_result_t;

  // one 64-bit word, read as a product or as rem/quot
  typedef union packed {
    logic [muldiv_cfg_pkg::RESULT_W-1:0] product;
    div_result_t                         divres;
  } muldiv_result_u;

endpackage

`default_nettype wire

// File: muldiv_cfg_pkg.sv
/*
 * sizes and depths for the multiply/divide unit
 * also holds the state codes shared by both iterative units
 */
`default_nettype none

package muldiv_cfg_pkg;

  // datapath sizes
  localparam int DATA_W      = 32;
  localparam int RESULT_W    = 64;
  localparam int CNT_W       = 5;

  // queue and order FIFO depths
  localparam int REQ_DEPTH   = 2;
  localparam int ORDER_DEPTH = 2;

  // iterative unit controller states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CALC = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

endpackage

`default_nettype wire
